// ==== source/fir_pkg.sv ====
package fir_pkg;

    // datapath sizes
    localparam int WORD_W   = 16;
    localparam int NUM_TAPS = 4;
    // four 32-bit products need two guard bits
    localparam int ACC_W    = 34;

    // register map, even base addresses
    localparam logic [3:0] ADDR_STATUS = 4'd0;
    localparam logic [3:0] ADDR_RESULT = 4'd2;
    localparam logic [3:0] ADDR_SAMPLE = 4'd4;
    localparam logic [3:0] ADDR_COEF0  = 4'd6;
    localparam logic [3:0] ADDR_LOAD   = 4'd14;

    // htrans encoding, anything other than idle is a transfer
    localparam logic [1:0] HTRANS_IDLE = 2'b00;

    // byte lanes of one register word
    typedef struct packed {
        logic [7:0] hi_byte;
        logic [7:0] lo_byte;
    } reg_bytes_t;

    // halfword accesses use word, byte accesses use bytes
    typedef union packed {
        logic [WORD_W-1:0] word;
        reg_bytes_t        bytes;
    } reg_word_u;

endpackage

// ==== source/fir_ifs.sv ====
`timescale 1ns/1ps

// register block to coefficient loader
interface coeff_if import fir_pkg::*; ();

    logic                        new_coefficient_set;
    logic [WORD_W-1:0]           fir_coefficient;
    logic [$clog2(NUM_TAPS)-1:0] coefficient_num;
    logic                        load_done;

    modport slave (
        output new_coefficient_set, fir_coefficient,
        input  coefficient_num, load_done
    );

    modport loader (
        input  new_coefficient_set, fir_coefficient,
        output coefficient_num, load_done
    );

endinterface

// register block to filter engine
interface sample_if import fir_pkg::*; ();

    logic [WORD_W-1:0] sample_data;
    logic              data_ready;
    logic              modwait;
    logic [WORD_W-1:0] fir_out;
    logic              err;

    modport slave (
        output sample_data, data_ready,
        input  modwait, fir_out, err
    );

    modport engine (
        input  sample_data, data_ready,
        output modwait, fir_out, err
    );

endinterface

// ==== source/ahb_lite_slave.sv ====
`timescale 1ns/1ps

module ahb_lite_slave
    import fir_pkg::*;
(
    input  logic              clk,
    input  logic              n_rst,
    input  logic              hsel,
    input  logic [3:0]        haddr,
    input  logic              hsize,
    input  logic [1:0]        htrans,
    input  logic              hwrite,
    input  logic [WORD_W-1:0] hwdata,
    output logic [WORD_W-1:0] hrdata,
    output logic              hresp,
    coeff_if.slave            cif,
    sample_if.slave           smp
);

    logic       addr_phase;
    logic       data_phase;
    logic [3:0] addr_q;
    logic       write_q;
    logic       size_q;
    logic [2:0] reg_sel;
    logic [1:0] coef_sel;
    logic       sel_coef;
    logic       illegal;
    logic       wr_en;
    logic       load_req;
    logic       ready_q;
    reg_word_u  sample_q;
    reg_word_u  coef_table [NUM_TAPS];
    reg_word_u  status_word;
    reg_word_u  rd_word;

    // merge a write into one register, odd address picks the upper lane
    function automatic reg_word_u lane_write(
        input reg_word_u         cur,
        input logic [WORD_W-1:0] wdata,
        input logic              halfword,
        input logic              upper
    );
        reg_word_u nxt;
        nxt = cur;
        if (halfword) begin
            nxt.word = wdata;
        end else if (upper) begin
            nxt.bytes.hi_byte = wdata[15:8];
        end else begin
            nxt.bytes.lo_byte = wdata[7:0];
        end
        return nxt;
    endfunction

    assign addr_phase = hsel && (htrans != HTRANS_IDLE);

    // halfword slot of the captured address
    assign reg_sel  = addr_q[3:1];
    assign sel_coef = (reg_sel >= ADDR_COEF0[3:1]) && (reg_sel < ADDR_LOAD[3:1]);
    assign coef_sel = 2'(reg_sel - ADDR_COEF0[3:1]);

    // all eight halfword slots are mapped, so only these can fail
    assign illegal = (write_q && (reg_sel == ADDR_STATUS[3:1] || reg_sel == ADDR_RESULT[3:1]))
                  || (!size_q && addr_q == 4'hF);

    assign hresp = data_phase && illegal;
    assign wr_en = data_phase && write_q && !illegal;

    assign status_word.word = {7'b0, smp.err, 6'b0, load_req, smp.modwait};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            data_phase <= 1'b0;
            addr_q     <= '0;
            write_q    <= 1'b0;
            size_q     <= 1'b0;
        end else begin
            data_phase <= addr_phase;
            if (addr_phase) begin
                addr_q  <= haddr;
                write_q <= hwrite;
                size_q  <= hsize;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sample_q.word <= '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef_table[i].word <= '0;
            end
            load_req <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            if (cif.load_done) begin
                load_req <= 1'b0;
            end
            if (wr_en) begin
                if (reg_sel == ADDR_SAMPLE[3:1]) begin
                    sample_q <= lane_write(sample_q, hwdata, size_q, addr_q[0]);
                    // low byte alone leaves the sample incomplete
                    ready_q  <= size_q || addr_q[0];
                end else if (sel_coef) begin
                    coef_table[coef_sel] <= lane_write(coef_table[coef_sel], hwdata,
                                                       size_q, addr_q[0]);
                end else if (reg_sel == ADDR_LOAD[3:1]) begin
                    load_req <= hwdata[0];
                end
            end
        end
    end

    always_comb begin
        rd_word.word = '0;
        if (reg_sel == ADDR_STATUS[3:1]) begin
            rd_word = status_word;
        end else if (reg_sel == ADDR_RESULT[3:1]) begin
            rd_word.word = smp.fir_out;
        end else if (reg_sel == ADDR_SAMPLE[3:1]) begin
            rd_word = sample_q;
        end else if (sel_coef) begin
            rd_word = coef_table[coef_sel];
        end else begin
            rd_word.word = {{(WORD_W-1){1'b0}}, load_req};
        end
    end

    always_comb begin
        hrdata = '0;
        if (data_phase && !write_q && !illegal) begin
            if (size_q) begin
                hrdata = rd_word.word;
            end else if (addr_q[0]) begin
                hrdata = {rd_word.bytes.hi_byte, 8'h00};
            end else begin
                hrdata = {8'h00, rd_word.bytes.lo_byte};
            end
        end
    end

    assign cif.new_coefficient_set = load_req;
    assign cif.fir_coefficient     = coef_table[cif.coefficient_num].word;
    assign smp.sample_data         = sample_q.word;
    assign smp.data_ready          = ready_q;

    // an erroring access writes no register
    error_changes_no_state: assert property (
        @(posedge clk) disable iff (!n_rst)
        hresp && !cif.load_done |=> $stable(sample_q.word) && $stable(load_req) && !ready_q
    );

endmodule

// ==== source/coefficient_loader.sv ====
`timescale 1ns/1ps

module coefficient_loader
    import fir_pkg::*;
(
    input  logic                        clk,
    input  logic                        n_rst,
    coeff_if.loader                     cif,
    input  logic                        modwait,
    output logic                        loading,
    output logic                        coeff_wr,
    output logic [$clog2(NUM_TAPS)-1:0] coeff_idx,
    output logic [WORD_W-1:0]           coeff_value
);

    localparam logic [1:0] LD_IDLE = 2'd0;
    localparam logic [1:0] LD_LOAD = 2'd1;
    localparam logic [1:0] LD_DONE = 2'd2;
    localparam logic [$clog2(NUM_TAPS)-1:0] LAST_IDX = $clog2(NUM_TAPS)'(NUM_TAPS - 1);

    logic [1:0]                  state;
    logic [1:0]                  state_n;
    logic [$clog2(NUM_TAPS)-1:0] idx_q;
    logic                        start;

    // wait for the engine to finish its current sample
    assign start = (state == LD_IDLE) && cif.new_coefficient_set && !modwait;

    always_comb begin
        state_n = state;
        case (state)
            LD_IDLE: if (start) state_n = LD_LOAD;
            LD_LOAD: if (idx_q == LAST_IDX) state_n = LD_DONE;
            default: state_n = LD_IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= LD_IDLE;
            idx_q <= '0;
        end else begin
            state <= state_n;
            idx_q <= (state == LD_LOAD) ? idx_q + 1'b1 : '0;
        end
    end

    // start is included so a sample arriving on the same edge is refused
    assign loading             = (state != LD_IDLE) || start;
    assign coeff_wr            = (state == LD_LOAD);
    assign coeff_idx           = idx_q;
    assign coeff_value         = cif.fir_coefficient;
    assign cif.coefficient_num = idx_q;
    assign cif.load_done       = (state == LD_DONE);

    coeff_idx_steps: assert property (
        @(posedge clk) disable iff (!n_rst)
        coeff_wr && (coeff_idx != LAST_IDX) |=> coeff_wr && (coeff_idx == $past(coeff_idx) + 1'b1)
    );

endmodule

// ==== source/fir_engine.sv ====
`timescale 1ns/1ps

module fir_engine
    import fir_pkg::*;
(
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        loading,
    input  logic                        coeff_wr,
    input  logic [$clog2(NUM_TAPS)-1:0] coeff_idx,
    input  logic [WORD_W-1:0]           coeff_value,
    sample_if.engine                    smp
);

    localparam int TAP_W = $clog2(NUM_TAPS);
    // Q1.15 coefficients, so the result drops 15 fraction bits
    localparam int RES_LSB = WORD_W - 1;
    localparam logic [TAP_W:0] STORE_STEP = NUM_TAPS[TAP_W:0];

    logic [WORD_W-1:0]   coef_q [NUM_TAPS];
    logic [WORD_W-1:0]   hist_q [NUM_TAPS];
    logic [ACC_W-1:0]    acc_q;
    logic [TAP_W:0]      step_q;
    logic                busy_q;
    logic                loading_q;
    logic [WORD_W-1:0]   fir_out_q;
    logic                err_q;
    logic                accept;
    logic                drop;
    logic [2*WORD_W-1:0] product;
    logic                overflow;

    assign accept   = smp.data_ready && !busy_q && !loading;
    assign drop     = smp.data_ready && !accept;
    assign product  = hist_q[step_q[TAP_W-1:0]] * coef_q[step_q[TAP_W-1:0]];
    // anything above bit 30 would not fit after the shift
    assign overflow = |acc_q[ACC_W-1:RES_LSB+WORD_W];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coef_q[i] <= '0;
            end
        end else if (coeff_wr) begin
            coef_q[coeff_idx] <= coeff_value;
        end
    end

    // newest sample at index 0
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist_q[i] <= '0;
            end
        end else if (accept) begin
            hist_q[0] <= smp.sample_data;
            for (int i = 1; i < NUM_TAPS; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            busy_q    <= 1'b0;
            loading_q <= 1'b0;
            step_q    <= '0;
            acc_q     <= '0;
            fir_out_q <= '0;
            err_q     <= 1'b0;
        end else begin
            loading_q <= loading;
            if (accept) begin
                busy_q <= 1'b1;
                step_q <= '0;
                acc_q  <= '0;
                err_q  <= 1'b0;
            end else if (busy_q) begin
                if (step_q < STORE_STEP) begin
                    acc_q  <= acc_q + ACC_W'(product);
                    step_q <= step_q + 1'b1;
                end else begin
                    // saturate and store, busy drops on this edge
                    busy_q    <= 1'b0;
                    fir_out_q <= overflow ? '1 : acc_q[RES_LSB +: WORD_W];
                    if (overflow) begin
                        err_q <= 1'b1;
                    end
                end
            end
            if (drop) begin
                err_q <= 1'b1;
            end
        end
    end

    assign smp.modwait = busy_q || loading_q;
    assign smp.fir_out = fir_out_q;
    assign smp.err     = err_q;

    no_coeff_wr_while_busy: assert property (
        @(posedge clk) disable iff (!n_rst)
        busy_q |-> !coeff_wr
    );

endmodule

// ==== source/ahb_lite_fir_filter.sv ====
`timescale 1ns/1ps

module ahb_lite_fir_filter
    import fir_pkg::*;
(
    input  logic              clk,
    input  logic              n_rst,
    input  logic              hsel,
    input  logic [3:0]        haddr,
    input  logic              hsize,
    input  logic [1:0]        htrans,
    input  logic              hwrite,
    input  logic [WORD_W-1:0] hwdata,
    output logic [WORD_W-1:0] hrdata,
    output logic              hresp
);

    // loader to engine
    logic                        loading;
    logic                        coeff_wr;
    logic [$clog2(NUM_TAPS)-1:0] coeff_idx;
    logic [WORD_W-1:0]           coeff_value;

    coeff_if  cif ();
    sample_if smp ();

    ahb_lite_slave u_slave (
        .clk    (clk),
        .n_rst  (n_rst),
        .hsel   (hsel),
        .haddr  (haddr),
        .hsize  (hsize),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hresp  (hresp),
        .cif    (cif.slave),
        .smp    (smp.slave)
    );

    coefficient_loader u_loader (
        .clk         (clk),
        .n_rst       (n_rst),
        .cif         (cif.loader),
        .modwait     (smp.modwait),
        .loading     (loading),
        .coeff_wr    (coeff_wr),
        .coeff_idx   (coeff_idx),
        .coeff_value (coeff_value)
    );

    fir_engine u_engine (
        .clk         (clk),
        .n_rst       (n_rst),
        .loading     (loading),
        .coeff_wr    (coeff_wr),
        .coeff_idx   (coeff_idx),
        .coeff_value (coeff_value),
        .smp         (smp.engine)
    );

endmodule

// ==== dv/fir_checker.sv ====
`timescale 1ns/1ps

module fir_checker
    import fir_pkg::*;
(
    input logic              clk,
    input logic              n_rst,
    input logic              hsel,
    input logic [3:0]        haddr,
    input logic              hsize,
    input logic [1:0]        htrans,
    input logic              hwrite,
    input logic [WORD_W-1:0] hwdata,
    input logic [WORD_W-1:0] hrdata,
    input logic              hresp
);

    int                fail_count = 0;
    int                pass_count = 0;
    int                test_errs = 0;
    int                busy_cnt;
    logic              dphase;
    logic [3:0]        addr_q;
    logic              write_q;
    logic              size_q;
    logic [WORD_W-1:0] obs_rdata;
    logic              obs_resp;
    logic [WORD_W-1:0] sample_m;
    logic [WORD_W-1:0] result_m;
    logic [WORD_W-1:0] table_m [NUM_TAPS];
    logic [WORD_W-1:0] coef_m [NUM_TAPS];
    logic [WORD_W-1:0] hist_m [NUM_TAPS];

    // writes to status or result, and byte access at 15
    function automatic logic is_illegal(input logic [3:0] a, input logic wr, input logic sz);
        return (wr && a[3:1] <= ADDR_RESULT[3:1]) || (!sz && a == 4'hF);
    endfunction

    function automatic logic [WORD_W-1:0] merge_lanes(input logic [WORD_W-1:0] cur,
                                                      input logic [WORD_W-1:0] wd,
                                                      input logic sz, input logic upper);
        if (sz) begin
            return wd;
        end
        if (upper) begin
            return {wd[15:8], cur[7:0]};
        end
        return {cur[15:8], wd[7:0]};
    endfunction

    task automatic accept_sample();
        longint acc;
        acc = 0;
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            hist_m[i] = hist_m[i-1];
        end
        hist_m[0] = sample_m;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc = acc + longint'(hist_m[i]) * longint'(coef_m[i]);
        end
        // Q1.15 coefficients
        acc = acc >> 15;
        result_m = (acc > 64'hFFFF) ? 16'hFFFF : acc[15:0];
        // data_ready refused for NUM_TAPS+1 edges after the accepting one
        busy_cnt = NUM_TAPS + 2;
    endtask

    always @(posedge clk or negedge n_rst) begin
        logic [2:0] slot;
        if (!n_rst) begin
            dphase = 1'b0;
            busy_cnt = 0;
            sample_m = '0;
            result_m = '0;
            for (int i = 0; i < NUM_TAPS; i++) begin
                table_m[i] = '0;
                coef_m[i] = '0;
                hist_m[i] = '0;
            end
        end else begin
            if (busy_cnt > 0) begin
                busy_cnt--;
            end
            slot = addr_q[3:1];
            if (dphase && write_q && !is_illegal(addr_q, write_q, size_q)) begin
                if (slot == ADDR_SAMPLE[3:1]) begin
                    sample_m = merge_lanes(sample_m, hwdata, size_q, addr_q[0]);
                    if ((size_q || addr_q[0]) && busy_cnt == 0) begin
                        accept_sample();
                    end
                end else if (slot >= ADDR_COEF0[3:1] && slot < ADDR_LOAD[3:1]) begin
                    table_m[2'(slot - ADDR_COEF0[3:1])] =
                        merge_lanes(table_m[2'(slot - ADDR_COEF0[3:1])], hwdata, size_q, addr_q[0]);
                end else if (slot == ADDR_LOAD[3:1] && hwdata[0]) begin
                    coef_m = table_m;
                end
            end
            dphase = hsel && (htrans != HTRANS_IDLE);
            if (dphase) begin
                addr_q = haddr;
                write_q = hwrite;
                size_q = hsize;
            end
        end
    end

    // outputs settle after the edge that opens the data phase
    always @(negedge clk) begin
        if (dphase) begin
            obs_rdata = hrdata;
            obs_resp = hresp;
        end
    end

    task automatic compare(input string name, input logic [WORD_W-1:0] exp,
                           input logic [WORD_W-1:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_resp(input logic exp_resp);
        compare("hresp", {15'b0, exp_resp}, {15'b0, obs_resp});
    endtask

    task automatic check_read(input logic [WORD_W-1:0] exp, input logic exp_resp);
        compare("hrdata", exp, obs_rdata);
        check_resp(exp_resp);
    endtask

    task automatic check_result();
        check_read(result_m, 1'b0);
    endtask

    task automatic finish_test(input int num);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %0d passed", num);
        end else begin
            fail_count++;
            $display("test %0d failed with %0d mismatches", num, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic print_counts();
        $display("tests %0d, passed %0d, failed %0d", pass_count + fail_count, pass_count,
                 fail_count);
    endtask

endmodule

// ==== dv/tb_ahb_lite_fir_filter.sv ====
`timescale 1ns/1ps

module tb_ahb_lite_fir_filter import fir_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam logic [2:0] OP_WR = 3'd0;
    localparam logic [2:0] OP_RD = 3'd1;
    localparam logic [2:0] OP_SAMPLE = 3'd2;
    localparam logic [2:0] OP_FIXED = 3'd3;
    localparam logic [2:0] OP_DROP = 3'd4;
    localparam logic [2:0] OP_RESULT = 3'd5;
    localparam logic [2:0] OP_LOAD_WAIT = 3'd6;

    typedef struct packed {
        logic [2:0]  op;
        logic [3:0]  addr;
        logic        size;
        logic [15:0] data;
        logic [15:0] exp;
        logic        resp;
    } test_t;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        hsel;
    logic [3:0]  haddr;
    logic        hsize;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [15:0] hwdata;
    logic [15:0] hrdata;
    logic        hresp;
    // data phase word of the last transfer
    logic [15:0] rdata;
    logic [31:0] lcg_state = 32'd86;
    test_t       tests[$];
    int          cycles = 0;
    int          cycle_limit;

    always #50 clk = ~clk;

    ahb_lite_fir_filter UUT (.*);

    fir_checker u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_test(input logic [2:0] op, input int addr, input int size,
                            input int data, input int exp, input int resp);
        tests.push_back(test_t'{op, 4'(addr), 1'(size), 16'(data), 16'(exp), 1'(resp)});
    endtask

    // one transfer, returns after the data phase
    task automatic bus_xfer(input logic wr, input logic [3:0] addr, input logic size,
                            input logic [15:0] data);
        @(negedge clk);
        hsel = 1'b1;
        haddr = addr;
        hsize = size;
        htrans = 2'b10;
        hwrite = wr;
        @(negedge clk);
        hsel = 1'b0;
        htrans = HTRANS_IDLE;
        hwdata = data;
        rdata = hrdata;
        @(posedge clk);
    endtask

    task automatic wait_clear(input int bit_num);
        logic [15:0] st;
        st = '1;
        while (st[bit_num]) begin
            bus_xfer(1'b0, ADDR_STATUS, 1'b1, 16'h0);
            st = rdata;
        end
    endtask

    task automatic run_test(input test_t t);
        logic [15:0] val;
        case (t.op)
            OP_WR: begin
                bus_xfer(1'b1, t.addr, t.size, t.data);
                u_checker.check_resp(t.resp);
            end
            OP_RD: begin
                bus_xfer(1'b0, t.addr, t.size, 16'h0);
                u_checker.check_read(t.exp, t.resp);
            end
            OP_LOAD_WAIT: wait_clear(1);
            default: begin
                if (t.op != OP_RESULT) begin
                    lcg_state = lcg_next(lcg_state);
                    val = (t.op == OP_FIXED) ? t.data : lcg_state[31:16];
                    bus_xfer(1'b1, ADDR_SAMPLE, 1'b1, val);
                    if (t.op == OP_DROP) begin
                        // engine still busy with the first one
                        lcg_state = lcg_next(lcg_state);
                        bus_xfer(1'b1, ADDR_SAMPLE, 1'b1, lcg_state[31:16]);
                    end
                    wait_clear(0);
                end
                bus_xfer(1'b0, ADDR_RESULT, 1'b1, 16'h0);
                u_checker.check_result();
            end
        endcase
    endtask

    task automatic build_table();
        for (int a = 0; a < 16; a += 2) begin
            add_test(OP_RD, a, 1, 0, 0, 0);
        end
        add_test(OP_WR, 6, 1, 'h1234, 0, 0);
        add_test(OP_RD, 6, 1, 0, 'h1234, 0);
        add_test(OP_WR, 9, 0, 'hAB00, 0, 0);
        add_test(OP_WR, 8, 0, 'h00CD, 0, 0);
        add_test(OP_RD, 8, 1, 0, 'hABCD, 0);
        add_test(OP_RD, 9, 0, 0, 'hAB00, 0);
        add_test(OP_RD, 8, 0, 0, 'h00CD, 0);
        // 0.5, 0.25, 0.125 and 0.0625
        for (int a = 6; a < 14; a += 2) begin
            add_test(OP_WR, a, 1, 'h8000 >> (a / 2 - 2), 0, 0);
        end
        // busy is also high while the loader runs
        add_test(OP_WR, 14, 1, 1, 0, 0);
        add_test(OP_RD, 0, 1, 0, 'h0003, 0);
        add_test(OP_LOAD_WAIT, 0, 0, 0, 0, 0);
        add_test(OP_RD, 14, 1, 0, 0, 0);
        for (int n = 0; n < 4; n++) begin
            add_test(OP_SAMPLE, 4, 1, 0, 0, 0);
        end
        add_test(OP_RD, 0, 1, 0, 0, 0);
        add_test(OP_WR, 0, 1, 'hFFFF, 0, 1);
        add_test(OP_WR, 2, 1, 'hFFFF, 0, 1);
        add_test(OP_WR, 15, 0, 'hFFFF, 0, 1);
        add_test(OP_RD, 15, 0, 0, 0, 1);
        add_test(OP_RD, 0, 1, 0, 0, 0);
        add_test(OP_RESULT, 2, 1, 0, 0, 0);
        add_test(OP_RD, 14, 1, 0, 0, 0);
        add_test(OP_DROP, 4, 1, 0, 0, 0);
        add_test(OP_RD, 0, 1, 0, 'h0100, 0);
        add_test(OP_SAMPLE, 4, 1, 0, 0, 0);
        add_test(OP_RD, 0, 1, 0, 0, 0);
        // full-scale taps overflow
        for (int a = 6; a < 14; a += 2) begin
            add_test(OP_WR, a, 1, 'hFFFF, 0, 0);
        end
        add_test(OP_WR, 14, 1, 1, 0, 0);
        add_test(OP_LOAD_WAIT, 0, 0, 0, 0, 0);
        add_test(OP_FIXED, 4, 1, 'hFFFF, 0, 0);
        add_test(OP_RD, 0, 1, 0, 'h0100, 0);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence never finished", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        n_rst = 1'b0;
        hsel = 1'b0;
        haddr = 4'h0;
        hsize = 1'b0;
        htrans = HTRANS_IDLE;
        hwrite = 1'b0;
        hwdata = 16'h0;
        build_table();
        cycle_limit = tests.size() * 20 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(negedge clk);
        n_rst = 1'b1;
        foreach (tests[i]) begin
            run_test(tests[i]);
            u_checker.finish_test(i);
        end
        u_checker.print_counts();
        if (u_checker.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
source/fir_pkg.sv
source/fir_ifs.sv
source/ahb_lite_slave.sv
source/coefficient_loader.sv
source/fir_engine.sv
source/ahb_lite_fir_filter.sv
dv/fir_checker.sv
dv/tb_ahb_lite_fir_filter.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ahb_lite_fir_filter
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' compile.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): compile.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f compile.f

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	@if grep -q '^=== PASS ===$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
